// File: hw/sparcIsaPkg.sv
package sparcIsaPkg;

    // LSB of each instruction field
    localparam int OpLsb = 30;
    localparam int RdLsb = 25;
    localparam int Op2Lsb = 22;
    localparam int Op3Lsb = 19;
    localparam int Rs1Lsb = 14;
    localparam int IBit = 13; // Selects simm13 over rs2
    localparam int Rs2Lsb = 0;

    localparam int RegAddrW = 5;
    localparam int Simm13W = 13;
    localparam int Imm22W = 22;
    localparam int SethiShift = 10;

    localparam logic [1:0] OpMem = 2'b11;
    localparam logic [1:0] OpFmt2 = 2'b00; // SETHI, branches and NOP
    localparam logic [2:0] Op2Sethi = 3'b100;

    // Load and store group
    localparam logic [5:0] Op3Ldsb = 6'b001001;
    localparam logic [5:0] Op3Ldsh = 6'b001010;
    localparam logic [5:0] Op3Ld = 6'b000000;
    localparam logic [5:0] Op3Ldub = 6'b000001;
    localparam logic [5:0] Op3Lduh = 6'b000010;
    localparam logic [5:0] Op3Stb = 6'b000101;
    localparam logic [5:0] Op3Sth = 6'b000110;
    localparam logic [5:0] Op3St = 6'b000100;

    typedef enum logic [1:0] {
        SizeByte = 2'b00,
        SizeHalf = 2'b01,
        SizeWord = 2'b10
    } accessSizeT;

    typedef struct packed {
        logic memEnable;
        logic isStore;
        accessSizeT accessSize;
        logic signExtend;
        logic rfWrite;
        logic isSethi;
        logic illegal;
    } decodedCtrlT;

endpackage

// File: hw/lsuCfgPkg.sv
package lsuCfgPkg;

    localparam int DataW = 32;
    localparam int NumRegs = 32;
    localparam int MemBytes = 512;
    localparam int MemAddrW = 9;
    localparam int ApbAddrW = 12;

    // APB address map
    localparam logic [ApbAddrW-1:0] AddrInstr = 12'h000;
    localparam logic [ApbAddrW-1:0] AddrRegBase = 12'h080; // r0 here and rn at base + 4n
    localparam logic [ApbAddrW-1:0] AddrRegLast = 12'h0FC;

endpackage

// File: hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
(
    input  logic [lsuCfgPkg::DataW-1:0] instr,
    output sparcIsaPkg::decodedCtrlT    ctrl
);

    logic [1:0] op;
    logic [2:0] op2;
    logic [5:0] op3;
    sparcIsaPkg::accessSizeT sizeFromOp3;

    assign op = instr[sparcIsaPkg::OpLsb +: 2];
    assign op2 = instr[sparcIsaPkg::Op2Lsb +: 3];
    assign op3 = instr[sparcIsaPkg::Op3Lsb +: 6];

    // Low two op3 bits carry the access size in this group
    always_comb
    begin
        case (op3[1:0])
            2'b01: sizeFromOp3 = sparcIsaPkg::SizeByte;
            2'b10: sizeFromOp3 = sparcIsaPkg::SizeHalf;
            default: sizeFromOp3 = sparcIsaPkg::SizeWord;
        endcase
    end

    always_comb
    begin
        ctrl = '0; // NOP leaves everything off
        case (op)
            sparcIsaPkg::OpFmt2:
            begin
                if (instr != '0)
                begin
                    if (op2 == sparcIsaPkg::Op2Sethi)
                    begin
                        ctrl.isSethi = 1'b1;
                        ctrl.rfWrite = 1'b1;
                    end
                    else
                        ctrl.illegal = 1'b1; // Branches are not supported
                end
            end
            sparcIsaPkg::OpMem:
            begin
                case (op3)
                    sparcIsaPkg::Op3Ldsb, sparcIsaPkg::Op3Ldsh, sparcIsaPkg::Op3Ld,
                    sparcIsaPkg::Op3Ldub, sparcIsaPkg::Op3Lduh:
                    begin
                        ctrl.memEnable = 1'b1;
                        ctrl.rfWrite = 1'b1;
                        ctrl.accessSize = sizeFromOp3;
                        ctrl.signExtend = op3[3]; // Only LDSB and LDSH
                    end
                    sparcIsaPkg::Op3Stb, sparcIsaPkg::Op3Sth, sparcIsaPkg::Op3St:
                    begin
                        ctrl.memEnable = 1'b1;
                        ctrl.isStore = 1'b1;
                        ctrl.accessSize = sizeFromOp3;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            default: ctrl.illegal = 1'b1; // CALL and arithmetic formats
        endcase
    end

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps

module registerFile
(
    input  logic                             Clk,
    input  logic                             rst,
    input  logic [sparcIsaPkg::RegAddrW-1:0] rs1Addr,
    input  logic [sparcIsaPkg::RegAddrW-1:0] rs2Addr,
    input  logic [sparcIsaPkg::RegAddrW-1:0] rdAddr,
    input  logic [sparcIsaPkg::RegAddrW-1:0] hostRdAddr,
    input  logic                             rfWrEn,
    input  logic [sparcIsaPkg::RegAddrW-1:0] rfWrAddr,
    input  logic [lsuCfgPkg::DataW-1:0]      rfWrData,
    input  logic                             hostWrEn,
    input  logic [sparcIsaPkg::RegAddrW-1:0] hostWrAddr,
    input  logic [lsuCfgPkg::DataW-1:0]      hostWrData,
    output logic [lsuCfgPkg::DataW-1:0]      rs1Data,
    output logic [lsuCfgPkg::DataW-1:0]      rs2Data,
    output logic [lsuCfgPkg::DataW-1:0]      rdData,
    output logic [lsuCfgPkg::DataW-1:0]      hostRdData
);

    logic [lsuCfgPkg::DataW-1:0] regs [lsuCfgPkg::NumRegs];

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < lsuCfgPkg::NumRegs; i++)
                regs[i] <= '0;
        end
        else if (rfWrEn && rfWrAddr != '0)
            regs[rfWrAddr] <= rfWrData; // Exec writeback wins
        else if (hostWrEn && hostWrAddr != '0)
            regs[hostWrAddr] <= hostWrData;
    end

    // r0 always reads zero
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];
    assign rdData = (rdAddr == '0) ? '0 : regs[rdAddr];
    assign hostRdData = (hostRdAddr == '0) ? '0 : regs[hostRdAddr];

endmodule

// File: hw/dataMemory.sv
`timescale 1ns/1ps

module dataMemory
(
    input  logic                             Clk,
    input  logic                             memWrEn,
    input  logic [lsuCfgPkg::MemAddrW-1:0]   memAddr,
    input  logic [lsuCfgPkg::DataW-1:0]      memWrData,
    input  sparcIsaPkg::accessSizeT          memSize,
    input  logic                             memSignExt,
    output logic [lsuCfgPkg::DataW-1:0]      memRdData
);

    logic [7:0] mem [lsuCfgPkg::MemBytes];
    logic [lsuCfgPkg::MemAddrW-3:0] wordIdx;
    logic [7:0] w0, w1, w2, w3; // w0 is the most significant byte
    logic [7:0] byteSel;
    logic [15:0] halfSel;

    assign wordIdx = memAddr[lsuCfgPkg::MemAddrW-1:2];

    always_ff @(posedge Clk)
    begin
        if (memWrEn)
        begin
            case (memSize)
                sparcIsaPkg::SizeByte:
                    mem[memAddr] <= memWrData[7:0];
                sparcIsaPkg::SizeHalf:
                begin
                    mem[{memAddr[lsuCfgPkg::MemAddrW-1:1], 1'b0}] <= memWrData[15:8];
                    mem[{memAddr[lsuCfgPkg::MemAddrW-1:1], 1'b1}] <= memWrData[7:0];
                end
                default:
                begin
                    mem[{wordIdx, 2'b00}] <= memWrData[31:24];
                    mem[{wordIdx, 2'b01}] <= memWrData[23:16];
                    mem[{wordIdx, 2'b10}] <= memWrData[15:8];
                    mem[{wordIdx, 2'b11}] <= memWrData[7:0];
                end
            endcase
        end
    end

    // Read the whole word, then pick the lane
    assign w0 = mem[{wordIdx, 2'b00}];
    assign w1 = mem[{wordIdx, 2'b01}];
    assign w2 = mem[{wordIdx, 2'b10}];
    assign w3 = mem[{wordIdx, 2'b11}];

    always_comb
    begin
        case (memAddr[1:0])
            2'b00: byteSel = w0;
            2'b01: byteSel = w1;
            2'b10: byteSel = w2;
            default: byteSel = w3;
        endcase
        halfSel = memAddr[1] ? {w2, w3} : {w0, w1};
        case (memSize)
            sparcIsaPkg::SizeByte:
                memRdData = {{(lsuCfgPkg::DataW - 8){memSignExt & byteSel[7]}}, byteSel};
            sparcIsaPkg::SizeHalf:
                memRdData = {{(lsuCfgPkg::DataW - 16){memSignExt & halfSel[15]}}, halfSel};
            default:
                memRdData = {w0, w1, w2, w3};
        endcase
    end

endmodule

// File: hw/apbCommandPort.sv
`timescale 1ns/1ps

module apbCommandPort
(
    input  logic                             Clk,
    input  logic                             rst,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [lsuCfgPkg::ApbAddrW-1:0]   paddr,
    input  logic [lsuCfgPkg::DataW-1:0]      pwdata,
    input  logic [lsuCfgPkg::DataW-1:0]      hostRdData,
    input  logic                             done,
    input  logic                             illegal,
    output logic                             pready,
    output logic [lsuCfgPkg::DataW-1:0]      prdata,
    output logic                             pslverr,
    output logic [sparcIsaPkg::RegAddrW-1:0] hostRdAddr,
    output logic                             hostWrEn,
    output logic [sparcIsaPkg::RegAddrW-1:0] hostWrAddr,
    output logic [lsuCfgPkg::DataW-1:0]      hostWrData,
    output logic                             start,
    output logic [lsuCfgPkg::DataW-1:0]      instrWord
);

    typedef enum logic [1:0] {
        StIdle,   // Waiting for a transfer
        StAccess, // Instruction in flight, waiting for done
        StWait    // Response cycle
    } stateT;

    stateT state;
    stateT nextState;
    logic firstAccess;
    logic isInstr;
    logic isReg;
    logic errQ;
    logic [sparcIsaPkg::RegAddrW-1:0] regIdx;

    assign firstAccess = psel & penable & (state == StIdle);
    assign isInstr = (paddr == lsuCfgPkg::AddrInstr);
    assign isReg = (paddr >= lsuCfgPkg::AddrRegBase) && (paddr <= lsuCfgPkg::AddrRegLast) &&
                   (paddr[1:0] == 2'b00);
    assign regIdx = paddr[2 +: sparcIsaPkg::RegAddrW]; // Window base is 128-byte aligned

    assign hostRdAddr = regIdx;
    assign hostWrAddr = regIdx;
    assign hostWrData = pwdata;
    assign hostWrEn = firstAccess & pwrite & isReg;
    assign start = firstAccess & pwrite & isInstr;
    assign instrWord = pwdata; // Held stable by the host during the transfer

    always_comb
    begin
        nextState = state;
        case (state)
            StIdle:
                if (start)
                    nextState = StAccess;
            StAccess:
                if (done)
                    nextState = StWait;
            default:
                nextState = StIdle;
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            state <= StIdle;
            errQ <= 1'b0;
        end
        else
        begin
            state <= nextState;
            if (state == StAccess && done)
                errQ <= illegal;
        end
    end

    always_comb
    begin
        pready = 1'b0;
        pslverr = 1'b0;
        prdata = '0;
        if (state == StWait)
        begin
            pready = 1'b1;
            pslverr = errQ;
        end
        else if (firstAccess && !start)
        begin
            pready = 1'b1; // Window access or error completes at once
            pslverr = !isReg;
            if (!pwrite && isReg)
                prdata = hostRdData;
        end
    end

endmodule

// File: hw/loadStoreExec.sv
`timescale 1ns/1ps

module loadStoreExec
(
    input  logic                             Clk,
    input  logic                             rst,
    input  logic                             start,
    input  logic [lsuCfgPkg::DataW-1:0]      instrWord,
    input  sparcIsaPkg::decodedCtrlT         ctrl,
    input  logic [lsuCfgPkg::DataW-1:0]      rs1Data,
    input  logic [lsuCfgPkg::DataW-1:0]      rs2Data,
    input  logic [lsuCfgPkg::DataW-1:0]      rdData,
    input  logic [lsuCfgPkg::DataW-1:0]      memRdData,
    output logic [sparcIsaPkg::RegAddrW-1:0] rs1Addr,
    output logic [sparcIsaPkg::RegAddrW-1:0] rs2Addr,
    output logic [sparcIsaPkg::RegAddrW-1:0] rdAddr,
    output logic                             rfWrEn,
    output logic [sparcIsaPkg::RegAddrW-1:0] rfWrAddr,
    output logic [lsuCfgPkg::DataW-1:0]      rfWrData,
    output logic                             memWrEn,
    output logic [lsuCfgPkg::MemAddrW-1:0]   memAddr,
    output logic [lsuCfgPkg::DataW-1:0]      memWrData,
    output sparcIsaPkg::accessSizeT          memSize,
    output logic                             memSignExt,
    output logic                             done,
    output logic                             illegal
);

    logic [lsuCfgPkg::DataW-1:0] simmExt;
    logic [lsuCfgPkg::DataW-1:0] effAddr;
    logic [lsuCfgPkg::MemAddrW-1:0] alignedAddr;
    logic busyQ; // Access stage valid
    sparcIsaPkg::decodedCtrlT ctrlQ;
    logic [lsuCfgPkg::MemAddrW-1:0] addrQ;
    logic [lsuCfgPkg::DataW-1:0] storeDataQ;
    logic [sparcIsaPkg::RegAddrW-1:0] rdQ;
    logic [sparcIsaPkg::Imm22W-1:0] imm22Q;

    assign rs1Addr = instrWord[sparcIsaPkg::Rs1Lsb +: sparcIsaPkg::RegAddrW];
    assign rs2Addr = instrWord[sparcIsaPkg::Rs2Lsb +: sparcIsaPkg::RegAddrW];
    assign rdAddr = instrWord[sparcIsaPkg::RdLsb +: sparcIsaPkg::RegAddrW];

    assign simmExt = {{(lsuCfgPkg::DataW - sparcIsaPkg::Simm13W){
                          instrWord[sparcIsaPkg::Simm13W-1]}},
                      instrWord[sparcIsaPkg::Simm13W-1:0]};
    assign effAddr = rs1Data + (instrWord[sparcIsaPkg::IBit] ? simmExt : rs2Data);

    // Wrap to memory size, then drop the low bits by access size
    always_comb
    begin
        alignedAddr = effAddr[lsuCfgPkg::MemAddrW-1:0];
        if (ctrl.accessSize == sparcIsaPkg::SizeHalf)
            alignedAddr[0] = 1'b0;
        else if (ctrl.accessSize == sparcIsaPkg::SizeWord)
            alignedAddr[1:0] = 2'b00;
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            busyQ <= 1'b0;
            ctrlQ <= '0;
        end
        else
        begin
            busyQ <= start;
            if (start)
                ctrlQ <= ctrl;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (start)
        begin
            addrQ <= alignedAddr;
            storeDataQ <= rdData; // Store source is rd
            rdQ <= rdAddr;
            imm22Q <= instrWord[sparcIsaPkg::Imm22W-1:0];
        end
    end

    assign memAddr = addrQ;
    assign memWrData = storeDataQ;
    assign memSize = ctrlQ.accessSize;
    assign memSignExt = ctrlQ.signExtend;
    assign memWrEn = busyQ & ctrlQ.memEnable & ctrlQ.isStore;

    assign rfWrEn = busyQ & ctrlQ.rfWrite;
    assign rfWrAddr = rdQ;
    assign rfWrData = ctrlQ.isSethi ? {imm22Q, {sparcIsaPkg::SethiShift{1'b0}}} : memRdData;

    assign done = busyQ;
    assign illegal = busyQ & ctrlQ.illegal;

endmodule

// File: hw/sparcLsuTop.sv
`timescale 1ns/1ps

module sparcLsuTop
(
    input  logic                           Clk,
    input  logic                           rst,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [lsuCfgPkg::ApbAddrW-1:0] paddr,
    input  logic [lsuCfgPkg::DataW-1:0]    pwdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic [lsuCfgPkg::DataW-1:0]    prdata
);

    logic [sparcIsaPkg::RegAddrW-1:0] hostRdAddr;
    logic [lsuCfgPkg::DataW-1:0] hostRdData;
    logic hostWrEn;
    logic [sparcIsaPkg::RegAddrW-1:0] hostWrAddr;
    logic [lsuCfgPkg::DataW-1:0] hostWrData;
    logic start;
    logic [lsuCfgPkg::DataW-1:0] instrWord;
    logic done;
    logic illegal;
    sparcIsaPkg::decodedCtrlT ctrl;
    logic [sparcIsaPkg::RegAddrW-1:0] rs1Addr;
    logic [sparcIsaPkg::RegAddrW-1:0] rs2Addr;
    logic [sparcIsaPkg::RegAddrW-1:0] rdAddr;
    logic [lsuCfgPkg::DataW-1:0] rs1Data;
    logic [lsuCfgPkg::DataW-1:0] rs2Data;
    logic [lsuCfgPkg::DataW-1:0] rdData;
    logic rfWrEn;
    logic [sparcIsaPkg::RegAddrW-1:0] rfWrAddr;
    logic [lsuCfgPkg::DataW-1:0] rfWrData;
    logic memWrEn;
    logic [lsuCfgPkg::MemAddrW-1:0] memAddr;
    logic [lsuCfgPkg::DataW-1:0] memWrData;
    logic [lsuCfgPkg::DataW-1:0] memRdData;
    sparcIsaPkg::accessSizeT memSize;
    logic memSignExt;

    apbCommandPort u_apb
    (
        .Clk(Clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .hostRdData(hostRdData), .done(done),
        .illegal(illegal), .pready(pready), .prdata(prdata), .pslverr(pslverr),
        .hostRdAddr(hostRdAddr), .hostWrEn(hostWrEn), .hostWrAddr(hostWrAddr),
        .hostWrData(hostWrData), .start(start), .instrWord(instrWord)
    );

    instrDecoder u_decoder
    (
        .instr(instrWord), .ctrl(ctrl)
    );

    loadStoreExec u_exec
    (
        .Clk(Clk), .rst(rst), .start(start), .instrWord(instrWord), .ctrl(ctrl),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .rdData(rdData), .memRdData(memRdData),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr), .rfWrEn(rfWrEn),
        .rfWrAddr(rfWrAddr), .rfWrData(rfWrData), .memWrEn(memWrEn), .memAddr(memAddr),
        .memWrData(memWrData), .memSize(memSize), .memSignExt(memSignExt),
        .done(done), .illegal(illegal)
    );

    registerFile u_regFile
    (
        .Clk(Clk), .rst(rst), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr),
        .hostRdAddr(hostRdAddr), .rfWrEn(rfWrEn), .rfWrAddr(rfWrAddr),
        .rfWrData(rfWrData), .hostWrEn(hostWrEn), .hostWrAddr(hostWrAddr),
        .hostWrData(hostWrData), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .rdData(rdData), .hostRdData(hostRdData)
    );

    dataMemory u_dataMem
    (
        .Clk(Clk), .memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData),
        .memSize(memSize), .memSignExt(memSignExt), .memRdData(memRdData)
    );

endmodule

// File: verif/sparcLsu_properties.sv
`timescale 1ns/1ps

module sparcLsu_properties
(
    input logic Clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic start,
    input logic done
);

    int errNoReady = 0;
    int lateReady = 0;
    int lostDone = 0;
    logic [1:0] waitCycles; // Access cycles so far without pready

    always_ff @(posedge Clk)
    begin
        if (rst)
            waitCycles <= 2'd0;
        else if (psel && penable && !pready)
            waitCycles <= waitCycles + 2'd1;
        else
            waitCycles <= 2'd0;
    end

    errWithReady: assert property (@(posedge Clk) disable iff (rst) pslverr |-> pready)
    else
    begin
        errNoReady++;
        $error("pslverr was high without pready");
    end

    // Third access cycle must complete
    readyInTime: assert property (@(posedge Clk) disable iff (rst)
        (psel && penable) |-> (waitCycles != 2'd2 || pready))
    else
    begin
        lateReady++;
        $error("pready did not come within three access cycles");
    end

    doneAfterStart: assert property (@(posedge Clk) disable iff (rst) start |=> done)
    else
    begin
        lostDone++;
        $error("done did not follow start by one cycle");
    end

endmodule

bind apbCommandPort sparcLsu_properties u_props
(
    .Clk(Clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr),
    .start(start),
    .done(done)
);

// File: verif/sparcLsuTb.sv
`timescale 1ns/1ps

module sparcLsuTb;

    localparam int NumWinWrites = 40;
    localparam int NumSethi = 16;
    localparam int NumSizedOps = 60;
    localparam int NumRegRegOps = 30;
    localparam int NumMemChecks = 8;
    localparam int MemWords = lsuCfgPkg::MemBytes / 4;
    // Upper bound of APB transfers summed over the tests
    localparam int TotalXfers = (NumWinWrites + 34) + 2 * NumSethi + 2 * MemWords + 12 +
        3 * NumSizedOps + (4 * NumRegRegOps + 8) + (41 + 2 * NumMemChecks) +
        (33 + 2 * NumMemChecks);
    localparam int TimeoutCycles = 20 * TotalXfers;

    logic Clk;
    logic rst;
    logic psel;
    logic penable;
    logic pwrite;
    logic [lsuCfgPkg::ApbAddrW-1:0] paddr;
    logic [lsuCfgPkg::DataW-1:0] pwdata;
    logic pready;
    logic pslverr;
    logic [lsuCfgPkg::DataW-1:0] prdata;

    integer seed = 32'h4e837ded;
    int errorCount = 0;
    int cycleCount = 0;
    int assertFails;
    logic [31:0] modelRegs [32];
    logic [7:0] modelMem [lsuCfgPkg::MemBytes];
    logic [5:0] memOps [8];

    sparcLsuTop u_dut
    (
        .Clk(Clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pready(pready), .pslverr(pslverr),
        .prdata(prdata)
    );

    always #4 Clk = ~Clk;

    always @(posedge Clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] randWord();
        randWord = $random(seed);
    endfunction

    function automatic logic [11:0] regAddr(input logic [4:0] idx);
        regAddr = lsuCfgPkg::AddrRegBase + {5'b0, idx, 2'b00}; // Word per register
    endfunction

    function automatic logic [31:0] memInstr(input logic [5:0] op3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic useImm,
                                             input logic [12:0] simm, input logic [4:0] rs2);
        memInstr = {sparcIsaPkg::OpMem, rd, op3, rs1, useImm, useImm ? simm : {8'b0, rs2}};
    endfunction

    function automatic int accessBytes(input logic [5:0] op3);
        case (op3)
            sparcIsaPkg::Op3Ldsb, sparcIsaPkg::Op3Ldub, sparcIsaPkg::Op3Stb: return 1;
            sparcIsaPkg::Op3Ldsh, sparcIsaPkg::Op3Lduh, sparcIsaPkg::Op3Sth: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic isStoreOp(input logic [5:0] op3);
        return op3 == sparcIsaPkg::Op3Stb || op3 == sparcIsaPkg::Op3Sth ||
               op3 == sparcIsaPkg::Op3St;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        if (actVal !== expVal)
        begin
            errorCount++;
            $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expVal, actVal);
        end
    endtask

    // Setup cycle, then access cycles until pready
    task automatic apbXfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
        @(posedge Clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge Clk);
        penable <= 1'b1;
        @(negedge Clk);
        while (!pready)
            @(negedge Clk);
        rdata = prdata;
        err = pslverr;
        @(posedge Clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic writeReg(input logic [4:0] idx, input logic [31:0] data);
        logic [31:0] unused;
        logic err;
        apbXfer(1'b1, regAddr(idx), data, unused, err);
        checkValue("window write pslverr", 32'd0, {31'b0, err});
        if (idx != 5'd0)
            modelRegs[idx] = data;
    endtask

    task automatic readReg(input logic [4:0] idx, output logic [31:0] data);
        logic err;
        apbXfer(1'b0, regAddr(idx), 32'd0, data, err);
        checkValue("window read pslverr", 32'd0, {31'b0, err});
    endtask

    task automatic readRegCheck(input logic [4:0] idx, input string name);
        logic [31:0] v;
        readReg(idx, v);
        checkValue(name, modelRegs[idx], v);
    endtask

    task automatic checkAllRegs(input string name);
        for (int i = 0; i < 32; i++)
            readRegCheck(5'(i), name);
    endtask

    task automatic runInstr(input logic [31:0] instr, input logic expErr, input string name);
        logic [31:0] unused;
        logic err;
        apbXfer(1'b1, lsuCfgPkg::AddrInstr, instr, unused, err);
        checkValue({name, " pslverr"}, {31'b0, expErr}, {31'b0, err});
    endtask

    task automatic memOp(input logic [5:0] op3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic useImm, input logic [12:0] simm, input logic [4:0] rs2,
                         input string name);
        logic [31:0] offset;
        logic [31:0] sum;
        logic [8:0] ea;
        logic [31:0] loaded;
        int n;
        offset = useImm ? {{19{simm[12]}}, simm} : modelRegs[rs2];
        sum = modelRegs[rs1] + offset;
        ea = sum[8:0]; // Wraps at 512 bytes
        n = accessBytes(op3);
        if (n == 2)
            ea[0] = 1'b0;
        else if (n == 4)
            ea[1:0] = 2'b00;
        runInstr(memInstr(op3, rd, rs1, useImm, simm, rs2), 1'b0, name);
        if (isStoreOp(op3))
        begin
            for (int i = 0; i < n; i++)
                modelMem[int'(ea) + i] = modelRegs[rd][8 * (n - 1 - i) +: 8]; // MSB first
        end
        else
        begin
            loaded = '0;
            for (int i = 0; i < n; i++)
                loaded = {loaded[23:0], modelMem[int'(ea) + i]};
            if (op3 == sparcIsaPkg::Op3Ldsb)
                loaded = {{24{loaded[7]}}, loaded[7:0]};
            else if (op3 == sparcIsaPkg::Op3Ldsh)
                loaded = {{16{loaded[15]}}, loaded[15:0]};
            if (rd != 5'd0)
                modelRegs[rd] = loaded;
            readRegCheck(rd, name);
        end
    endtask

    // Load into r6 and compare with a fixed value
    task automatic loadLiteral(input logic [5:0] op3, input logic [12:0] addr,
                               input logic [31:0] expVal, input string name);
        logic [31:0] v;
        runInstr(memInstr(op3, 5'd6, 5'd0, 1'b1, addr, 5'd0), 1'b0, name);
        readReg(5'd6, v);
        checkValue(name, expVal, v);
        modelRegs[6] = expVal;
    endtask

    // First samples cover the NOP target and the illegal store target
    task automatic checkMemSample(input string name);
        logic [31:0] r;
        logic [12:0] addr;
        for (int k = 0; k < NumMemChecks; k++)
        begin
            r = randWord();
            if (k == 0)
                addr = 13'h000;
            else if (k == 1)
                addr = 13'h020;
            else
                addr = {4'b0, r[8:2], 2'b00};
            memOp(sparcIsaPkg::Op3Ld, 5'd7, 5'd0, 1'b1, addr, 5'd0, name);
        end
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] v;
        logic err;
        logic [5:0] op3;
        Clk = 1'b0;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;
        memOps = '{sparcIsaPkg::Op3Ldsb, sparcIsaPkg::Op3Ldsh, sparcIsaPkg::Op3Ld,
                   sparcIsaPkg::Op3Ldub, sparcIsaPkg::Op3Lduh, sparcIsaPkg::Op3Stb,
                   sparcIsaPkg::Op3Sth, sparcIsaPkg::Op3St};
        repeat (8) @(posedge Clk);
        rst <= 1'b0;

        // Register window
        for (int k = 0; k < NumWinWrites; k++)
        begin
            r = randWord();
            v = randWord();
            writeReg(r[4:0], v);
        end
        writeReg(5'd0, 32'hdeadbeef);
        readReg(5'd0, v);
        checkValue("r0 after write", 32'd0, v);
        checkAllRegs("window readback");

        for (int k = 0; k < NumSethi; k++)
        begin
            r = randWord();
            runInstr({sparcIsaPkg::OpFmt2, r[31:27], sparcIsaPkg::Op2Sethi, r[21:0]}, 1'b0,
                     "sethi");
            if (r[31:27] != 5'd0)
                modelRegs[r[31:27]] = {r[21:0], 10'b0};
            readRegCheck(r[31:27], "sethi");
        end

        // Every byte gets a known value before any load
        for (int a = 0; a < MemWords; a++)
        begin
            r = randWord() ^ {23'b0, 9'(a * 4)};
            writeReg(5'd5, r);
            memOp(sparcIsaPkg::Op3St, 5'd5, 5'd0, 1'b1, 13'(a * 4), 5'd0, "fill");
        end

        writeReg(5'd4, 32'h0000a1b2);
        memOp(sparcIsaPkg::Op3Sth, 5'd4, 5'd0, 1'b1, 13'h041, 5'd0, "halfword store");
        loadLiteral(sparcIsaPkg::Op3Ldub, 13'h040, 32'h000000a1, "big-endian high byte");
        loadLiteral(sparcIsaPkg::Op3Ldub, 13'h041, 32'h000000b2, "big-endian low byte");
        loadLiteral(sparcIsaPkg::Op3Ldsb, 13'h040, 32'hffffffa1, "signed byte");
        loadLiteral(sparcIsaPkg::Op3Lduh, 13'h041, 32'h0000a1b2, "unsigned half");
        loadLiteral(sparcIsaPkg::Op3Ldsh, 13'h040, 32'hffffa1b2, "signed half");

        for (int k = 0; k < NumSizedOps; k++)
        begin
            r = randWord();
            op3 = memOps[r[2:0]];
            if (isStoreOp(op3))
                writeReg(r[7:3], randWord());
            memOp(op3, r[7:3], r[12:8], 1'b1, r[25:13], 5'd0, "sized access");
        end

        for (int k = 0; k < NumRegRegOps; k++)
        begin
            r = randWord();
            op3 = memOps[r[2:0]];
            writeReg(5'd1, randWord());
            writeReg(5'd2, randWord());
            if (isStoreOp(op3))
                writeReg(r[7:3], randWord());
            memOp(op3, r[7:3], 5'd1, 1'b0, 13'd0, 5'd2, "reg plus reg");
        end

        // 510 + 5 wraps to byte 3 and the word store lands at 0
        writeReg(5'd1, 32'd510);
        writeReg(5'd2, 32'd5);
        writeReg(5'd3, 32'h13579bdf);
        memOp(sparcIsaPkg::Op3St, 5'd3, 5'd1, 1'b0, 13'd0, 5'd2, "wrapped store");
        loadLiteral(sparcIsaPkg::Op3Ld, 13'h000, 32'h13579bdf, "wrapped word");

        runInstr(32'h86004002, 1'b1, "illegal add");
        runInstr(32'h40000010, 1'b1, "illegal call");
        runInstr(32'h10800004, 1'b1, "illegal branch");
        runInstr(memInstr(6'b000111, 5'd9, 5'd0, 1'b1, 13'h020, 5'd0), 1'b1, "illegal std");
        runInstr(memInstr(6'b001101, 5'd9, 5'd0, 1'b1, 13'h020, 5'd0), 1'b1, "illegal ldstub");
        apbXfer(1'b1, 12'h004, 32'h12345678, v, err);
        checkValue("unmapped write pslverr", 32'd1, {31'b0, err});
        apbXfer(1'b0, 12'h100, 32'd0, v, err);
        checkValue("unmapped read pslverr", 32'd1, {31'b0, err});
        apbXfer(1'b0, 12'h082, 32'd0, v, err);
        checkValue("misaligned window pslverr", 32'd1, {31'b0, err});
        apbXfer(1'b0, lsuCfgPkg::AddrInstr, 32'd0, v, err);
        checkValue("instruction port read pslverr", 32'd1, {31'b0, err});
        checkAllRegs("regs after errors");
        checkMemSample("memory after errors");

        runInstr(32'h00000000, 1'b0, "nop");
        checkAllRegs("regs after nop");
        checkMemSample("memory after nop");

        assertFails = u_dut.u_apb.u_props.errNoReady + u_dut.u_apb.u_props.lateReady +
                      u_dut.u_apb.u_props.lostDone;
        $display("Run finished with %0d value errors and %0d assertion failures",
                 errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: tb.f
hw/sparcIsaPkg.sv
hw/lsuCfgPkg.sv
hw/instrDecoder.sv
hw/registerFile.sv
hw/dataMemory.sv
hw/apbCommandPort.sv
hw/loadStoreExec.sv
hw/sparcLsuTop.sv
verif/sparcLsu_properties.sv
verif/sparcLsuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module sparcLsuTb \
    --Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
    echo "Failure found in $LOG"
    exit 1
fi

exit 0
